//--- common/gc_pkg.sv
// ========================================
// Garbler shared definitions
// Gate opcodes, stream tags, FSM states
// and netlist word field positions
// ========================================

package gc_pkg;

	// Truth-table encoding, out for {in0,in1} = 11,10,01,00
	typedef enum logic [3:0] {
		GATE_NOT  = 4'b0011,
		GATE_XOR  = 4'b0110,
		GATE_XNOR = 4'b1001
	} gate_op_e;

	// Output stream tags, upper bit marks an input-label beat
	typedef enum logic [2:0] {
		TAG_NONE  = 3'b000,
		TAG_KEYS  = 3'b001,
		TAG_MASKS = 3'b011,
		TAG_IN0   = 3'b101,
		TAG_IN1   = 3'b110,
		TAG_IN01  = 3'b111
	} tag_e;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		GETKEYS,
		INPUTS,
		GARBLE,
		MASKS,
		DONE
	} state_e;

	// Netlist word layout
	localparam int OP_MSB = 31;
	localparam int OP_LSB = 28;
	localparam int A_MSB  = 27;  // Header 0: input count, gate: in0
	localparam int A_LSB  = 14;
	localparam int B_MSB  = 13;  // Header 0: gate count, header 1: output count, gate: in1
	localparam int B_LSB  = 0;

	// Wires 0 and 1 hold the constant labels
	localparam int FIRST_INPUT_WIRE = 2;

endpackage

//--- rtl/netlist_store.sv
// ========================================
// Netlist store
// Takes the header and gate words after a start
// pulse and serves gate fields by address
// ========================================
`timescale 1ns/100ps

module netlist_store
	import gc_pkg::*;
#(
	parameter int S = 8
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  logic         netlist_valid,
	input  logic [31:0]  netlist_in,
	input  logic [S-1:0] rd_addr,
	output logic         ready,
	output logic [S-1:0] input_count,
	output logic [S-1:0] gate_count,
	output logic [S-1:0] output_count,
	output gate_op_e     op,
	output logic [S-1:0] in0,
	output logic [S-1:0] in1
);
	logic [31:0]          gate_mem [2**S];
	logic [31:0]          rd_word;
	logic [S:0]           word_cnt;  // Words taken since start
	logic                 loading;
	logic                 take;
	logic                 last_word;
	logic [A_MSB-A_LSB:0] in_a;
	logic [B_MSB-B_LSB:0] in_b;
	logic [A_MSB-A_LSB:0] rd_a;
	logic [B_MSB-B_LSB:0] rd_b;

	assign in_a      = netlist_in[A_MSB:A_LSB];
	assign in_b      = netlist_in[B_MSB:B_LSB];
	assign take      = loading && netlist_valid;
	assign last_word = take && (word_cnt == {1'b0, gate_count} + 1'b1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			loading      <= 1'b0;
			ready        <= 1'b0;
			word_cnt     <= '0;
			input_count  <= '0;
			gate_count   <= '0;
			output_count <= '0;
		end else if (start) begin
			loading  <= 1'b1;
			ready    <= 1'b0;
			word_cnt <= '0;
		end else if (take) begin
			word_cnt <= word_cnt + 1'b1;
			if (word_cnt == '0) begin
				input_count <= in_a[S-1:0];
				gate_count  <= in_b[S-1:0];
			end
			if (word_cnt == (S+1)'(1))
				output_count <= in_b[S-1:0];
			if (last_word) begin
				loading <= 1'b0;
				ready   <= 1'b1;
			end
		end
	end

	// Gate words follow the two header words
	always_ff @(posedge clk) begin
		if (take && (word_cnt >= (S+1)'(2)))
			gate_mem[S'(word_cnt - 2'd2)] <= netlist_in;
		rd_word <= gate_mem[rd_addr];
	end

	assign rd_a = rd_word[A_MSB:A_LSB];
	assign rd_b = rd_word[B_MSB:B_LSB];
	assign op   = gate_op_e'(rd_word[OP_MSB:OP_LSB]);
	assign in0  = rd_a[S-1:0];
	assign in1  = rd_b[S-1:0];

endmodule

//--- rtl/label_gen.sv
// ========================================
// Label generator
// Two Galois LFSRs, each stepped by its own
// enable so every label handed out is fresh
// ========================================
`timescale 1ns/100ps

module label_gen
	import gc_pkg::*;
#(
	parameter int K = 128
) (
	input  logic         clk,
	input  logic         rst,
	input  logic [1:0]   en,
	output logic [K-1:0] key0,
	output logic [K-1:0] key1
);
	// Taps of x^128 + x^7 + x^2 + x + 1
	localparam logic [K-1:0] TAPS  = K'(8'h87);
	localparam logic [K-1:0] SEED0 = K'(128'h6a09e667_f3bcc908_bb67ae85_84caa73b);
	localparam logic [K-1:0] SEED1 = K'(128'h3c6ef372_fe94f82b_a54ff53a_5f1d36f1);

	logic [K-1:0] lfsr0;
	logic [K-1:0] lfsr1;

	function automatic logic [K-1:0] lfsr_step(input logic [K-1:0] s);
		return {s[K-2:0], 1'b0} ^ (s[K-1] ? TAPS : '0);
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lfsr0 <= SEED0;
			lfsr1 <= SEED1;
		end else begin
			if (en[0]) lfsr0 <= lfsr_step(lfsr0);
			if (en[1]) lfsr1 <= lfsr_step(lfsr1);
		end
	end

	assign key0 = lfsr0;  // Current value is the label
	assign key1 = lfsr1;

endmodule

//--- rtl/label_ram.sv
// ========================================
// Wire-label memory
// One label and one written flag per wire,
// one write port and two synchronous reads
// ========================================
`timescale 1ns/100ps

module label_ram
	import gc_pkg::*;
#(
	parameter int S = 8,
	parameter int K = 128
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         clr,
	input  logic         wr_en,
	input  logic [S-1:0] wr_addr,
	input  logic [K-1:0] wr_data,
	input  logic [S-1:0] rd_addr0,
	input  logic [S-1:0] rd_addr1,
	output logic [K-1:0] rd_data0,
	output logic [K-1:0] rd_data1,
	output logic         rd_ready0,
	output logic         rd_ready1
);
	logic [K-1:0]    mem [2**S];
	logic [2**S-1:0] written;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data0 <= mem[rd_addr0];  // Old data on a same-cycle write
		rd_data1 <= mem[rd_addr1];
	end

	// Written flags with the same read timing as the data
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			written   <= '0;
			rd_ready0 <= 1'b0;
			rd_ready1 <= 1'b0;
		end else begin
			if (clr)
				written <= '0;
			else if (wr_en)
				written[wr_addr] <= 1'b1;
			rd_ready0 <= written[rd_addr0];
			rd_ready1 <= written[rd_addr1];
		end
	end

endmodule

//--- garbler/gate_eval.sv
// ========================================
// Free-XOR gate evaluation
// Output label of XOR, XNOR and NOT gates,
// registered with its wire number
// ========================================
`timescale 1ns/100ps

module gate_eval
	import gc_pkg::*;
#(
	parameter int S = 8,
	parameter int K = 128
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         in_valid,
	input  gate_op_e     op,
	input  logic [S-1:0] in_wire,
	input  logic [K-1:0] label0,
	input  logic [K-1:0] label1,
	input  logic [K-1:0] r,
	output logic         out_valid,
	output logic [S-1:0] out_wire,
	output logic [K-1:0] out_label
);
	logic [K-1:0] result;

	always_comb begin
		case (op)
			GATE_XNOR: result = label0 ^ label1 ^ r;
			GATE_NOT:  result = label0 ^ r;  // in1 not used
			default:   result = label0 ^ label1;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		out_wire  <= in_wire;
		out_label <= result;
	end

endmodule

//--- garbler/garbler_ctrl.sv
// ========================================
// Garbler control
// FSM, label draw, gate issue with replay on
// unready operands, masks and output stream
// ========================================
`timescale 1ns/100ps

module garbler_ctrl
	import gc_pkg::*;
#(
	parameter int S = 8,
	parameter int K = 128
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  logic         nl_ready,
	input  logic [S-1:0] input_count,
	input  logic [S-1:0] gate_count,
	input  logic [S-1:0] output_count,
	input  gate_op_e     op,
	input  logic [S-1:0] in0,
	input  logic [S-1:0] in1,
	input  logic [K-1:0] key0,
	input  logic [K-1:0] key1,
	input  logic [K-1:0] rd_data0,
	input  logic [K-1:0] rd_data1,
	input  logic         rd_ready0,
	input  logic         rd_ready1,
	output logic [S-1:0] nl_addr,
	output logic [1:0]   key_en,
	output logic         clr,
	output logic         wr_en,
	output logic [S-1:0] wr_addr,
	output logic [K-1:0] wr_data,
	output logic [S-1:0] rd_addr0,
	output logic [S-1:0] rd_addr1,
	output tag_e         tag,
	output logic [S-1:0] index0,
	output logic [S-1:0] index1,
	output logic [K-1:0] data0,
	output logic [K-1:0] data1,
	output logic         done
);
	state_e         state;
	state_e         next_state;
	gate_op_e       s2_op;
	tag_e           tag_n;
	logic [K-1:0]   r_q;
	logic [K-1:0]   r_new;
	logic           sec_pend;  // Second label of a pair still to be written
	logic [S-1:0]   sec_addr;
	logic [K-1:0]   sec_data;
	logic [S-1:0]   inp_wire;
	logic [S-1:0]   inp_left;
	logic           draw;
	logic           draw_two;
	logic [S-1:0]   gate_idx;
	logic [S-1:0]   ret_cnt;
	logic [S-1:0]   gate_base;
	logic [S-1:0]   s1_idx;
	logic [S-1:0]   s2_idx;
	logic           s1_valid;
	logic           s2_valid;
	logic           issue;
	logic           fire;
	logic           flush;
	logic           ev_valid;
	logic [S-1:0]   ev_wire;
	logic [K-1:0]   ev_label;
	logic [S-1:0]   m_idx;
	logic [S-1:0]   m_q;
	logic [S-1:0]   out_base;
	logic           m_vld;
	logic           m_last;
	logic [2*K-1:0] mask_q;
	logic [S-1:0]   idx0_n;
	logic [S-1:0]   idx1_n;
	logic [K-1:0]   dat0_n;
	logic [K-1:0]   dat1_n;

	assign r_new     = {key0[K-1:1], 1'b1};
	assign gate_base = S'(FIRST_INPUT_WIRE) + input_count;
	assign out_base  = gate_base + gate_count - output_count;  // Outputs are the last gates
	assign draw      = (state == INPUTS) && !sec_pend && (inp_left != '0);
	assign draw_two  = (inp_left > S'(1));
	assign fire      = s2_valid && rd_ready0 && (rd_ready1 || s2_op == GATE_NOT);
	assign flush     = s2_valid && !fire;  // Replay from the stalled gate
	assign issue     = (state == GARBLE) && (gate_idx != gate_count) && !flush;
	assign m_last    = (m_idx == output_count) && !m_vld;
	assign nl_addr   = gate_idx;
	assign rd_addr0  = (state == MASKS) ? out_base + m_idx : in0;
	assign rd_addr1  = in1;
	assign clr       = (state == IDLE) && start;
	assign done      = (state == DONE);
	assign key_en    = (state == GETKEYS) ? 2'b11 : {draw && draw_two, draw};

	gate_eval #(.S(S), .K(K)) i_gate_eval (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (fire),
		.op        (s2_op),
		.in_wire   (gate_base + s2_idx),
		.label0    (rd_data0),
		.label1    (rd_data1),
		.r         (r_q),
		.out_valid (ev_valid),
		.out_wire  (ev_wire),
		.out_label (ev_label)
	);

	// Single write port, gate results only arrive in GARBLE
	always_comb begin
		wr_en   = 1'b1;
		wr_addr = ev_wire;
		wr_data = ev_label;
		if (state == GETKEYS) begin
			wr_addr = '0;  // Constant-zero wire
			wr_data = key1;
		end else if (sec_pend) begin
			wr_addr = sec_addr;
			wr_data = sec_data;
		end else if (draw) begin
			wr_addr = inp_wire;
			wr_data = key0;
		end else begin
			wr_en = ev_valid;
		end
	end

	always_comb begin
		tag_n  = TAG_NONE;
		idx0_n = '0;
		idx1_n = '0;
		dat0_n = '0;
		dat1_n = '0;
		if (state == GETKEYS) begin
			tag_n  = TAG_KEYS;
			dat0_n = r_new;
			dat1_n = key1;
		end else if (draw) begin
			tag_n  = draw_two ? TAG_IN01 : TAG_IN0;
			idx0_n = inp_wire;
			idx1_n = draw_two ? inp_wire + 1'b1 : '0;
			dat0_n = key0;
			dat1_n = draw_two ? key1 : '0;
		end else if ((state == MASKS) && m_last) begin
			tag_n  = TAG_MASKS;
			dat0_n = mask_q[K-1:0];
			dat1_n = mask_q[2*K-1:K];
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE:    if (start) next_state = LOAD;
			LOAD:    if (nl_ready) next_state = GETKEYS;
			GETKEYS: next_state = INPUTS;
			INPUTS:  if (!sec_pend && inp_left == '0) next_state = GARBLE;
			GARBLE:  if (ret_cnt == gate_count) next_state = MASKS;
			MASKS:   if (m_last) next_state = DONE;
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= IDLE;
			tag      <= TAG_NONE;
			sec_pend <= 1'b0;
			inp_wire <= '0;
			inp_left <= '0;
			gate_idx <= '0;
			ret_cnt  <= '0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			m_idx    <= '0;
			m_vld    <= 1'b0;
		end else begin
			state    <= next_state;
			tag      <= tag_n;
			s1_valid <= issue;
			s2_valid <= s1_valid && !flush;
			m_vld    <= (state == MASKS) && (m_idx != output_count);
			if (state == GETKEYS) begin
				sec_pend <= 1'b1;  // Constant-one label goes next
				inp_wire <= S'(FIRST_INPUT_WIRE);
				inp_left <= input_count;
				gate_idx <= '0;
				ret_cnt  <= '0;
				m_idx    <= '0;
			end else if (draw) begin
				sec_pend <= draw_two;
				inp_wire <= inp_wire + 2'd2;
				inp_left <= inp_left - (draw_two ? 2'd2 : 2'd1);
			end else if (state == INPUTS) begin
				sec_pend <= 1'b0;
			end
			if (flush)
				gate_idx <= s2_idx;
			else if (issue)
				gate_idx <= gate_idx + 1'b1;
			if (ev_valid)
				ret_cnt <= ret_cnt + 1'b1;
			if ((state == MASKS) && (m_idx != output_count))
				m_idx <= m_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == GETKEYS) begin
			r_q      <= r_new;
			mask_q   <= '0;
			sec_addr <= S'(1);
			sec_data <= key1 ^ r_new;
		end else if (draw) begin
			sec_addr <= inp_wire + 1'b1;
			sec_data <= key1;
		end
		if (m_vld)
			mask_q[m_q] <= rd_data0[0];  // Mask bit is the label lsb
		s1_idx <= gate_idx;
		s2_idx <= s1_idx;
		s2_op  <= op;
		m_q    <= m_idx;
		index0 <= idx0_n;
		index1 <= idx1_n;
		data0  <= dat0_n;
		data1  <= dat1_n;
	end

endmodule

//--- rtl/garbled_circuit.sv
// ========================================
// Garbled circuit front end
// Netlist store, label generator, label memory
// and free-XOR garbler, output as a tagged stream
// ========================================
`timescale 1ns/100ps

module garbled_circuit
	import gc_pkg::*;
#(
	parameter int S = 8,
	parameter int K = 128
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  logic         netlist_valid,
	input  logic [31:0]  netlist_in,
	output tag_e         tag,
	output logic [S-1:0] index0,
	output logic [S-1:0] index1,
	output logic [K-1:0] data0,
	output logic [K-1:0] data1,
	output logic         done
);
	logic           nl_ready;
	logic [S-1:0]   nl_addr;
	logic [S-1:0]   input_count;
	logic [S-1:0]   gate_count;
	logic [S-1:0]   output_count;
	gate_op_e       op;
	logic [S-1:0]   in0;
	logic [S-1:0]   in1;
	logic [1:0]     key_en;
	logic [K-1:0]   key0;
	logic [K-1:0]   key1;
	logic           clr;
	logic           wr_en;
	logic [S-1:0]   wr_addr;
	logic [K-1:0]   wr_data;
	logic [S-1:0]   rd_addr0;
	logic [S-1:0]   rd_addr1;
	logic [K-1:0]   rd_data0;
	logic [K-1:0]   rd_data1;
	logic           rd_ready0;
	logic           rd_ready1;

	netlist_store #(.S(S)) i_netlist_store (
		.clk, .rst, .start, .netlist_valid, .netlist_in,
		.rd_addr (nl_addr),
		.ready   (nl_ready),
		.input_count, .gate_count, .output_count, .op, .in0, .in1
	);

	label_gen #(.K(K)) i_label_gen (
		.clk, .rst,
		.en   (key_en),
		.key0, .key1
	);

	label_ram #(.S(S), .K(K)) i_label_ram (
		.clk, .rst, .clr, .wr_en, .wr_addr, .wr_data,
		.rd_addr0, .rd_addr1, .rd_data0, .rd_data1, .rd_ready0, .rd_ready1
	);

	garbler_ctrl #(.S(S), .K(K)) i_garbler_ctrl (
		.clk, .rst, .start, .nl_ready,
		.input_count, .gate_count, .output_count, .op, .in0, .in1,
		.key0, .key1, .rd_data0, .rd_data1, .rd_ready0, .rd_ready1,
		.nl_addr, .key_en, .clr, .wr_en, .wr_addr, .wr_data,
		.rd_addr0, .rd_addr1,
		.tag, .index0, .index1, .data0, .data1, .done
	);

endmodule

//--- testbench/garbled_circuit_props.sv
// ========================================
// Garbler stream properties
// Tag encoding, done alignment and one
// key beat per run
// ========================================
`timescale 1ns/100ps

module garbled_circuit_props
	import gc_pkg::*;
(
	input logic clk,
	input logic rst,
	input tag_e tag,
	input logic done
);
	logic [1:0] keys_seen;  // Key beats since the last done

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			keys_seen <= '0;
		else if (done)
			keys_seen <= '0;
		else if (tag == TAG_KEYS && keys_seen != 2'd3)
			keys_seen <= keys_seen + 1'b1;
	end

	tag_defined: assert property (@(posedge clk) disable iff (rst)
		tag inside {TAG_NONE, TAG_KEYS, TAG_MASKS, TAG_IN0, TAG_IN1, TAG_IN01})
		else $error("undefined stream tag %b", tag);

	done_with_masks: assert property (@(posedge clk) disable iff (rst)
		done == (tag == TAG_MASKS))
		else $error("done and the mask beat are not aligned");

	one_key_beat: assert property (@(posedge clk) disable iff (rst)
		(tag == TAG_KEYS) |-> (keys_seen == 2'd0))
		else $error("second key beat in one run");

	keys_before_done: assert property (@(posedge clk) disable iff (rst)
		done |-> (keys_seen == 2'd1))
		else $error("run ended without exactly one key beat");

endmodule

//--- testbench/tb_garbled_circuit.sv
// ========================================
// Garbler front end testbench
// Directed netlists, stream collection and
// a free-XOR reference model
// ========================================
`timescale 1ns/100ps

module tb_garbled_circuit
	import gc_pkg::*;
();
	localparam int S = 8;
	localparam int K = 128;
	localparam int W = 2 * K;

	logic         clk;
	logic         rst;
	logic         start;
	logic         netlist_valid;
	logic [31:0]  netlist_in;
	tag_e         tag;
	logic [S-1:0] index0;
	logic [S-1:0] index1;
	logic [K-1:0] data0;
	logic [K-1:0] data1;
	logic         done;

	logic [31:0]  nl_q [$];     // Words of the current netlist
	logic [K-1:0] lbl [int];    // Wire labels, stream values then model values
	logic [K-1:0] r_obs;
	int           n_in;
	int           n_gates;
	int           n_out;
	int           total_words = 0;
	int unsigned  rng_state = 86;

	garbled_circuit #(.S(S), .K(K)) i_garbled_circuit (
		.clk, .rst, .start, .netlist_valid, .netlist_in,
		.tag, .index0, .index1, .data0, .data1, .done
	);

	bind garbled_circuit garbled_circuit_props i_garbled_circuit_props (.clk, .rst, .tag, .done);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic int unsigned rand_below(input int unsigned n);
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return (rng_state >> 8) % n;
	endfunction

	function automatic gate_op_e random_op();
		case (rand_below(3))
			0:       return GATE_XOR;
			1:       return GATE_XNOR;
			default: return GATE_NOT;
		endcase
	endfunction

	task automatic check_value(input string test, input string what,
			input logic [W-1:0] expected, input logic [W-1:0] actual);
		assert (actual === expected) else begin
			$display("error %s: %s expected %h actual %h", test, what, expected, actual);
			$display("Something failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_true(input string test, input bit cond, input string msg);
		assert (cond) else begin
			$display("%s: %s", test, msg);
			$display("Something failed");
			$fatal(1, "check did not hold");
		end
	endtask

	task automatic new_netlist(input int inputs, input int gates, input int outputs);
		nl_q.delete();
		n_in    = inputs;
		n_gates = gates;
		n_out   = outputs;
		nl_q.push_back({4'h0, 14'(inputs), 14'(gates)});
		nl_q.push_back({4'h0, 14'd0, 14'(outputs)});
	endtask

	task automatic add_gate(input gate_op_e op, input int a, input int b);
		nl_q.push_back({op, 14'(a), 14'(b)});
	endtask

	// Load, run, collect the stream and compare with the model
	task automatic run_netlist(input string test);
		int           next_in;
		int           keys_cnt;
		int           gate_wire;
		int           out_base;
		bit           finished;
		logic [31:0]  w;
		logic [K-1:0] a;
		logic [K-1:0] b;
		logic [W-1:0] mask_exp;
		logic [W-1:0] mask_obs;

		total_words += nl_q.size();
		@(negedge clk);  // DONE state has gone back to IDLE
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		foreach (nl_q[i]) begin
			netlist_valid = 1'b1;
			netlist_in    = nl_q[i];
			@(negedge clk);
		end
		netlist_valid = 1'b0;
		next_in  = FIRST_INPUT_WIRE;
		keys_cnt = 0;
		finished = 1'b0;
		mask_obs = '0;
		while (!finished) begin
			@(negedge clk);
			case (tag)
				TAG_NONE: ;
				TAG_KEYS: begin
					keys_cnt++;
					r_obs  = data0;
					lbl[0] = data1;
					lbl[1] = data1 ^ data0;
				end
				TAG_IN01, TAG_IN0: begin
					check_true(test, keys_cnt == 1, "input beat without a key beat before it");
					check_value(test, "index0", W'(next_in), W'(index0));
					lbl[next_in] = data0;
					if (tag == TAG_IN01) begin
						check_true(test, next_in + 1 <= n_in + 1, "input pair past the last input");
						check_value(test, "index1", W'(next_in + 1), W'(index1));
						lbl[next_in + 1] = data1;
						next_in += 2;
					end else begin
						check_true(test, next_in == n_in + 1, "single input beat before the last input");
						next_in += 1;
					end
				end
				TAG_MASKS: mask_obs = {data1, data0};
				default: check_true(test, 1'b0, "undefined tag on the stream");
			endcase
			if (done) begin
				check_true(test, tag == TAG_MASKS, "done without the mask beat");
				finished = 1'b1;
			end
		end

		check_value(test, "key beats", W'(1), W'(keys_cnt));
		check_value(test, "R lsb", W'(1), W'(r_obs[0]));
		check_value(test, "next input wire", W'(n_in + FIRST_INPUT_WIRE), W'(next_in));
		for (int i = 0; i < n_in + FIRST_INPUT_WIRE; i++)
			for (int j = i + 1; j < n_in + FIRST_INPUT_WIRE; j++)
				if (i != 1 && j != 1)
					check_true(test, lbl[i] !== lbl[j], "two drawn labels are equal");

		// Free-XOR rules in gate order
		for (int g = 0; g < n_gates; g++) begin
			w         = nl_q[g + 2];
			gate_wire = FIRST_INPUT_WIRE + n_in + g;
			a         = lbl[int'(w[A_MSB:A_LSB])];
			b         = lbl[int'(w[B_MSB:B_LSB])];
			case (w[OP_MSB:OP_LSB])
				GATE_XOR:  lbl[gate_wire] = a ^ b;
				GATE_XNOR: lbl[gate_wire] = a ^ b ^ r_obs;
				default:   lbl[gate_wire] = a ^ r_obs;  // NOT
			endcase
		end
		mask_exp = '0;
		out_base = FIRST_INPUT_WIRE + n_in + n_gates - n_out;
		for (int j = 0; j < n_out; j++)
			mask_exp = mask_exp | (W'(lbl[out_base + j][0]) << j);
		check_value(test, "mask", mask_exp, mask_obs);
	endtask

	task automatic test_keys_and_inputs();
		new_netlist(7, 3, 2);  // Odd input count ends with a single beat
		add_gate(GATE_XOR, 2, 3);
		add_gate(GATE_XOR, 4, 8);
		add_gate(GATE_XNOR, 9, 10);
		run_netlist("keys_and_inputs");
	endtask

	task automatic test_xor_chain();
		new_netlist(4, 12, 1);
		add_gate(GATE_XOR, 2, 3);
		for (int g = 1; g < 12; g++)
			add_gate(GATE_XOR, 5 + g, 2 + (g % 4));  // Previous gate and an input
		run_netlist("xor_chain");
	endtask

	task automatic test_random_mix(input string test, input int inputs, input int gates,
			input int outputs);
		int w;

		new_netlist(inputs, gates, outputs);
		for (int g = 0; g < gates; g++) begin
			w = FIRST_INPUT_WIRE + inputs + g;
			add_gate(random_op(), rand_below(w), rand_below(w));  // Any earlier wire
		end
		run_netlist(test);
	endtask

	task automatic test_dependent_mix();
		int w;

		new_netlist(8, 40, 40);
		for (int g = 0; g < 40; g++) begin
			w = FIRST_INPUT_WIRE + 8 + g;
			if (g == 0)
				add_gate(GATE_XOR, 2, 3);
			else if (g % 2 == 1)
				add_gate(GATE_NOT, 2 + (g % 8), 0);  // Inputs only
			else if (g % 4 == 0)
				add_gate(GATE_XNOR, w - 1, w - 2);
			else
				add_gate(GATE_XOR, w - 1, 1);
		end
		run_netlist("dependent_mix");
	endtask

	task automatic test_second_run();
		logic [K-1:0] first_r;
		logic [K-1:0] first_in;

		first_r  = r_obs;
		first_in = lbl[FIRST_INPUT_WIRE];
		test_random_mix("second_run", 5, 30, 16);
		check_true("second_run", r_obs !== first_r, "R repeats the previous run");
		check_true("second_run", lbl[FIRST_INPUT_WIRE] !== first_in,
			"input label repeats the previous run");
	endtask

	initial begin : watchdog
		int cycles;

		cycles = 0;
		while (cycles <= total_words * 50 + 2000) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, no done after %0d cycles", cycles);
		$display("Something failed");
		$fatal(1, "timeout");
	end

	initial begin
		rst           = 1'b1;
		start         = 1'b0;
		netlist_valid = 1'b0;
		netlist_in    = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value("reset", "tag", W'(TAG_NONE), W'(tag));
		check_value("reset", "done", W'(0), W'(done));
		test_keys_and_inputs();
		test_xor_chain();
		test_random_mix("random_mix", 20, 200, 200);
		test_dependent_mix();
		test_second_run();
		$display("Everything OK");
		$finish;
	end

endmodule

//--- build.f
common/gc_pkg.sv
rtl/netlist_store.sv
rtl/label_gen.sv
rtl/label_ram.sv
garbler/gate_eval.sv
garbler/garbler_ctrl.sv
rtl/garbled_circuit.sv
testbench/garbled_circuit_props.sv
testbench/tb_garbled_circuit.sv

//--- Makefile
# Verilator build, run and lint for the garbled circuit front end

VERILATOR  ?= verilator
TOP        ?= tb_garbled_circuit
DUT_TOP    ?= garbled_circuit
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
